//--- deser.f
src/deser_link_pkg.sv
src/deser_align_pkg.sv
src/deser_timing_if.sv
src/deser_clock_ctrl.sv
src/deser_lane.sv
src/deser_data.sv
src/deserializer.sv
bench/deser_checker.sv
bench/tb_deserializer.sv

//--- Makefile
# Verilator build and run for the deserializer testbench

VERILATOR ?= verilator
TOP       ?= tb_deserializer
FILELIST  ?= deser.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert

BIN := $(BUILD_DIR)/V$(TOP)

SOURCES := $(shell cat $(FILELIST)) bench/deser_golden.txt

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, fail on a failing run"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

test: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/deser_golden.txt
// rnd lane0 lane1 lane2 lane3 slip expected check, one step per line
// rnd=1 lane words come from the lcg, check=0 expected word not compared
0 01 02 0B 04 0 000000 1
0 3F 00 0B 2A 0 10B081 1
0 15 2A 0B 3F 0 A8B03F 1
0 12 34 0B 05 0 FCBA95 1
0 21 0E 0B 33 0 14BD12 1
0 07 38 0B 1C 4 CE53A1 1
0 2D 11 0B 06 0 725E07 1
0 0F 30 0B 27 4 1B246D 1
0 3C 03 0B 18 4 9D9C0F 1
0 19 26 0B 0A 4 62C0FC 1
0 2E 1D 0B 31 4 296999 1
0 08 10 0B 20 4 C5676E 1
0 36 09 0B 13 0 80B408 1
0 1B 24 0B 2F 0 4CB276 1
0 04 3B 0B 0D 0 BCB91B 1
0 29 16 0B 3A 0 34BEC4 1
0 33 0C 0B 1E 0 E8B5A9 1
0 0A 35 0B 25 0 78B333 1
1 00 00 00 00 0 94BD4A 1
1 00 00 00 00 0 000000 0

//--- bench/tb_deserializer.sv
// deserializer testbench
`default_nettype none
`timescale 1ns/1ps

module tb_deserializer;

	import deser_link_pkg::*;
	import deser_align_pkg::*;

	localparam int STEPS     = 20;	// lines in the golden file
	localparam int COLS      = 8;	// rnd, 4 lane words, slip, expected, check
	localparam int RST_CYC   = 8;
	localparam int CYC_LIMIT = LOCK_CYCLES + RST_CYC + STEPS * DESER_WIDTH * 2;
	localparam int BUS_W     = CHANNEL_NUM * DESER_WIDTH;

	logic                   clk_io;
	logic                   rst_n;
	logic [CHANNEL_NUM-1:0] data_in;
	logic [CHANNEL_NUM-1:0] bitslip;
	logic                   lock;
	logic                   reset_recover;
	logic [BUS_W-1:0]       data_recover;
	logic                   data_valid;

	logic [31:0]      gold [0:STEPS*COLS-1];
	logic [31:0]      lcg_state;
	int               cyc = 0;
	int               valid_cnt;
	int               value_errs;
	int               other_errs;
	logic             lock_seen;
	int               exp_idx;
	logic [BUS_W-1:0] exp_data;
	logic             exp_chk;

	// ------------------------------------------------
	// clock, DUT and checker
	// ------------------------------------------------
	initial clk_io = 1'b0;
	always #5 clk_io = ~clk_io;	// 10 ns bit clock

	deserializer i_dut (
		.clk_io        (clk_io),
		.rst_n         (rst_n),
		.data_in       (data_in),
		.bitslip       (bitslip),
		.lock          (lock),
		.reset_recover (reset_recover),
		.data_recover  (data_recover),
		.data_valid    (data_valid)
	);

	// expected word for the next data_valid
	assign exp_idx  = (valid_cnt < STEPS) ? valid_cnt : STEPS - 1;
	assign exp_data = gold[exp_idx*COLS + 6][BUS_W-1:0];
	assign exp_chk  = (valid_cnt < STEPS) && gold[exp_idx*COLS + 7][0];

	deser_checker i_chk (
		.clk_io        (clk_io),
		.rst_n         (rst_n),
		.lock          (lock),
		.reset_recover (reset_recover),
		.data_recover  (data_recover),
		.data_valid    (data_valid),
		.exp_data      (exp_data),
		.exp_chk       (exp_chk),
		.valid_cnt     (valid_cnt),
		.value_errs    (value_errs),
		.other_errs    (other_errs),
		.lock_seen     (lock_seen)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// one word per lane, lsb first, slip pulse with bit 0
	task automatic send_step(input int j);
		lane_word_t             words [CHANNEL_NUM];
		logic [CHANNEL_NUM-1:0] bits;
		for (int c = 0; c < CHANNEL_NUM; c++) begin
			if (gold[j*COLS][0]) begin
				lcg_state = lcg_next(lcg_state);
				words[c]  = lcg_state[16 +: DESER_WIDTH];	// padding word
			end else begin
				words[c] = gold[j*COLS + 1 + c][DESER_WIDTH-1:0];
			end
		end
		for (int i = 0; i < DESER_WIDTH; i++) begin
			@(posedge clk_io);
			for (int c = 0; c < CHANNEL_NUM; c++)
				bits[c] = words[c][i];
			data_in <= bits;
			bitslip <= (i == 0) ? gold[j*COLS + 5][CHANNEL_NUM-1:0] : '0;
		end
	endtask

	// ------------------------------------------------
	// main sequence
	// ------------------------------------------------
	initial begin
		rst_n     <= 1'b0;
		data_in   <= '0;
		bitslip   <= '0;
		lcg_state = 32'h951538df;
		$readmemh("bench/deser_golden.txt", gold);
		repeat (RST_CYC) @(posedge clk_io);
		rst_n <= 1'b1;
		@(negedge clk_io);
		while (!lock) @(negedge clk_io);
		// bit 0 lands on the first edge after reset_recover drops
		repeat (RESET_SYNC_STAGES - 1) @(posedge clk_io);
		for (int j = 0; j < STEPS; j++)
			send_step(j);
		@(posedge clk_io);
		data_in <= '0;
		bitslip <= '0;
		while (valid_cnt < STEPS) @(negedge clk_io);
		$display("errors: value %0d, other %0d", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0 && lock_seen)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	// cycle limit, sized from the step count
	always @(posedge clk_io) begin
		cyc <= cyc + 1;
		if (cyc >= CYC_LIMIT) begin
			if (!lock_seen)
				$display("lock never rose within %0d cycles", CYC_LIMIT);
			else
				$display("run stopped at cycle limit with %0d of %0d words received",
					valid_cnt, STEPS);
			$display("errors: value %0d, other %0d", value_errs, other_errs + 1);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- bench/deser_checker.sv
// deserializer output checker
`default_nettype none
`timescale 1ns/1ps

module deser_checker (
	input  logic clk_io,
	input  logic rst_n,
	input  logic lock,
	input  logic reset_recover,
	input  logic [deser_link_pkg::CHANNEL_NUM*deser_link_pkg::DESER_WIDTH-1:0] data_recover,
	input  logic data_valid,
	input  logic [deser_link_pkg::CHANNEL_NUM*deser_link_pkg::DESER_WIDTH-1:0] exp_data,
	input  logic exp_chk,		// compare this word or skip it
	output int   valid_cnt,		// data_valid pulses so far
	output int   value_errs,
	output int   other_errs,
	output logic lock_seen
);

	import deser_link_pkg::*;
	import deser_align_pkg::*;

	int   n_valid = 0;
	int   n_value = 0;
	int   n_other = 0;
	int   rel_cyc = 0;		// edges since rst_n release
	int   rst_cyc = 0;		// edges spent in reset
	int   gap = 0;			// cycles since last data_valid
	logic got_lock = 1'b0;
	logic rec_seen = 1'b0;	// reset_recover has dropped
	logic run = 1'b0;		// first data_valid seen

	function automatic int compare_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERROR %s: expected %h actual %h at %0t", name, exp, act, $time);
			return 1;
		end
		return 0;
	endfunction

	// ------------------------------------------------
	// sampled on the falling edge, away from drive edge
	// ------------------------------------------------
	always @(negedge clk_io) begin : watch
		int o_err;
		int v_err;
		o_err = 0;
		v_err = 0;
		if (!rst_n) begin
			rel_cyc  <= 0;
			rst_cyc  <= rst_cyc + 1;
			rec_seen <= 1'b0;
			run      <= 1'b0;
			if (rst_cyc >= 2) begin	// flops settled by now
				v_err += compare_bit("lock", 1'b0, lock);
				v_err += compare_bit("reset_recover", 1'b1, reset_recover);
				v_err += compare_bit("data_valid", 1'b0, data_valid);
			end
		end else begin
			rel_cyc <= rel_cyc + 1;
			if (lock && !got_lock) begin
				got_lock <= 1'b1;
				if (rel_cyc != LOCK_CYCLES) begin
					$display("lock rose %0d cycles after reset release, expected %0d",
						rel_cyc, LOCK_CYCLES);
					o_err++;
				end
			end
			if (got_lock && !lock) begin
				$display("lock dropped while rst_n was high");
				o_err++;
			end
			if (!reset_recover && !rec_seen) begin
				rec_seen <= 1'b1;
				if (rel_cyc != LOCK_CYCLES + RESET_SYNC_STAGES) begin
					$display("reset_recover fell %0d cycles after reset release, expected %0d",
						rel_cyc, LOCK_CYCLES + RESET_SYNC_STAGES);
					o_err++;
				end
			end
			if (data_valid) begin
				if (run && gap != DESER_WIDTH) begin
					$display("data_valid came %0d cycles after the previous one, not %0d",
						gap, DESER_WIDTH);
					o_err++;
				end
				if (exp_chk && data_recover !== exp_data) begin
					$display("ERROR data_recover word %0d: expected %h actual %h",
						n_valid, exp_data, data_recover);
					v_err++;
				end
				run     <= 1'b1;
				gap     <= 1;
				n_valid <= n_valid + 1;
			end else begin
				gap <= gap + 1;
				if (run && gap == DESER_WIDTH) begin	// reported once per miss
					$display("data_valid missing, no word within %0d cycles", DESER_WIDTH);
					o_err++;
				end
			end
		end
		n_value <= n_value + v_err;
		n_other <= n_other + o_err;
	end

	assign valid_cnt  = n_valid;
	assign value_errs = n_value;
	assign other_errs = n_other;
	assign lock_seen  = got_lock;

endmodule

`default_nettype wire

//--- src/deserializer.sv
// source synchronous deserializer top
`default_nettype none
`timescale 1ns/1ps

module deserializer (
	// ------------------------------------------------
	// clock and reset
	// ------------------------------------------------
	input  logic clk_io,	// shared bit clock
	input  logic rst_n,		// sync, active low

	// ------------------------------------------------
	// serial side
	// ------------------------------------------------
	input  logic [deser_link_pkg::CHANNEL_NUM-1:0] data_in,	// one bit per lane
	input  logic [deser_link_pkg::CHANNEL_NUM-1:0] bitslip,	// per-lane slip pulse

	// ------------------------------------------------
	// recovered side
	// ------------------------------------------------
	output logic lock,			// emulated pll lock
	output logic reset_recover,	// high until lock has settled
	output logic [deser_link_pkg::CHANNEL_NUM*deser_link_pkg::DESER_WIDTH-1:0] data_recover,
	output logic data_valid		// one cycle per packed word
);

	// strobe, phase, lock and recovered reset between the halves
	deser_timing_if tim ();

	// lock counter, word phase and strobe
	deser_clock_ctrl deser_clock_ctrl_inst (
		.clk_io (clk_io),
		.rst_n  (rst_n),
		.tim    (tim)
	);

	// lanes plus packed output register
	deser_data deser_data_inst (
		.clk_io       (clk_io),
		.tim          (tim),
		.data_in      (data_in),
		.bitslip      (bitslip),
		.data_recover (data_recover),	// packed bus, same width as flat port
		.data_valid   (data_valid)
	);

	assign lock          = tim.lock;
	assign reset_recover = tim.reset_recover;

endmodule

`default_nettype wire

//--- src/deser_data.sv
// multi-lane data path
`default_nettype none
`timescale 1ns/1ps

module deser_data (
	input  logic                                  clk_io,	// bit clock
	deser_timing_if.data                          tim,
	input  logic [deser_link_pkg::CHANNEL_NUM-1:0] data_in,	// one bit per lane
	input  logic [deser_link_pkg::CHANNEL_NUM-1:0] bitslip,	// one pulse per lane
	output deser_link_pkg::data_bus_t             data_recover,
	output logic                                  data_valid
);

	import deser_link_pkg::*;

	data_bus_t lane_bus;	// lane words already in output slot order
	data_bus_t data_q;
	logic      valid_q;

	// ------------------------------------------------
	// lanes
	// ------------------------------------------------
	for (genvar c = 0; c < CHANNEL_NUM; c++) begin : g_lane
		// little endian puts channel 0 in the low slot
		localparam int SLOT = END_LITTLE ? c : CHANNEL_NUM - 1 - c;

		deser_lane deser_lane_inst (
			.clk_io  (clk_io),
			.tim     (tim),
			.data_in (data_in[c]),
			.bitslip (bitslip[c]),
			.word    (lane_bus[SLOT])
		);
	end

	// ------------------------------------------------
	// output register
	// ------------------------------------------------
	always_ff @(posedge clk_io) begin
		if (tim.serdesstrobe)
			data_q <= lane_bus;	// all lanes released together
	end

	always_ff @(posedge clk_io) begin
		if (tim.reset_recover)
			valid_q <= 1'b0;
		else
			valid_q <= tim.serdesstrobe;	// one cycle behind strobe
	end

	assign data_recover = data_q;
	assign data_valid   = valid_q;

	// ------------------------------------------------
	// checks
	// ------------------------------------------------
	a_valid_after_strobe : assert property (@(posedge clk_io)
		data_valid |-> $past(tim.serdesstrobe))
		else $error("data_valid without a preceding strobe");

endmodule

`default_nettype wire

//--- src/deser_lane.sv
// single lane deserializer
`default_nettype none
`timescale 1ns/1ps

module deser_lane (
	input  logic                    clk_io,		// bit clock
	deser_timing_if.data            tim,
	input  logic                    data_in,	// serial bit, sampled every edge
	input  logic                    bitslip,	// one cycle pulse
	output deser_link_pkg::lane_word_t word		// aligned word hold
);

	import deser_link_pkg::*;
	import deser_align_pkg::*;

	lane_word_t shift_q;	// last DESER_WIDTH bits received
	lane_word_t hold_q;
	phase_t     slip_ofs;	// phase at which the boundary falls

	// ------------------------------------------------
	// serial capture
	// ------------------------------------------------
	// lsb first: new bit enters on top and walks down to bit 0
	always_ff @(posedge clk_io) begin
		if (SER_FIRST_LSB)
			shift_q <= {data_in, shift_q[DESER_WIDTH-1:1]};
		else
			shift_q <= {shift_q[DESER_WIDTH-2:0], data_in};	// msb first
	end

	// ------------------------------------------------
	// bitslip
	// ------------------------------------------------
	// each pulse pushes the boundary one bit later
	always_ff @(posedge clk_io) begin
		if (tim.reset_recover) begin
			slip_ofs <= '0;
		end else if (bitslip) begin
			if (slip_ofs == PHASE_W'(SLIP_WRAP))
				slip_ofs <= '0;	// full word of slips, back to start
			else
				slip_ofs <= slip_ofs + 1'b1;
		end
	end

	// ------------------------------------------------
	// word hold
	// ------------------------------------------------
	// at phase == offset the register holds a complete word
	// starting at the bit sampled on phase == offset one word ago
	always_ff @(posedge clk_io) begin
		if (tim.phase == slip_ofs)
			hold_q <= shift_q;
	end

	assign word = hold_q;

	// slips are only meaningful once the link is running
	a_no_slip_in_reset : assert property (@(posedge clk_io)
		tim.reset_recover |-> !bitslip)
		else $error("bitslip pulsed during reset_recover");

endmodule

`default_nettype wire

//--- src/deser_clock_ctrl.sv
// deserializer clock controller
`default_nettype none
`timescale 1ns/1ps

module deser_clock_ctrl (
	input  logic        clk_io,	// bit clock
	input  logic        rst_n,	// sync, active low
	deser_timing_if.ctrl tim
);

	import deser_link_pkg::*;
	import deser_align_pkg::*;

	logic [LOCK_CNT_W-1:0]        lock_cnt;	// cycles since reset release
	logic                         lock_q;
	logic [RESET_SYNC_STAGES-1:0] rst_sync;	// shifts in !lock
	phase_t                       phase_q;
	logic                         strobe_q;

	// ------------------------------------------------
	// lock emulation
	// ------------------------------------------------
	// lock goes high after LOCK_CYCLES edges with rst_n high
	always_ff @(posedge clk_io) begin
		if (!rst_n) begin
			lock_cnt <= '0;
			lock_q   <= 1'b0;
		end else if (!lock_q) begin
			if (lock_cnt == LOCK_CNT_W'(LOCK_CYCLES - 1))
				lock_q <= 1'b1;	// sticky until next reset
			else
				lock_cnt <= lock_cnt + 1'b1;
		end
	end

	// recovered reset, released RESET_SYNC_STAGES cycles after lock
	always_ff @(posedge clk_io) begin
		if (!rst_n)
			rst_sync <= '1;
		else
			rst_sync <= {rst_sync[RESET_SYNC_STAGES-2:0], ~lock_q};
	end

	// ------------------------------------------------
	// word phase and strobe
	// ------------------------------------------------
	always_ff @(posedge clk_io) begin
		if (!rst_n || tim.reset_recover) begin
			phase_q  <= '0;	// parked at 0 until out of reset
			strobe_q <= 1'b0;
		end else begin
			if (phase_q == PHASE_W'(DESER_WIDTH - 1))
				phase_q <= '0;
			else
				phase_q <= phase_q + 1'b1;
			// lands high exactly when phase wraps to 0
			strobe_q <= (phase_q == PHASE_W'(DESER_WIDTH - 1));
		end
	end

	assign tim.lock          = lock_q;
	assign tim.reset_recover = rst_sync[RESET_SYNC_STAGES-1];
	assign tim.phase         = phase_q;
	assign tim.serdesstrobe  = strobe_q;

	// ------------------------------------------------
	// checks
	// ------------------------------------------------
	// first strobe comes a full word after reset_recover drops
	a_no_strobe_in_reset : assert property (@(posedge clk_io)
		tim.reset_recover |-> !tim.serdesstrobe)
		else $error("serdesstrobe fired during reset_recover");

	// lock is sticky, only rst_n may clear it
	a_lock_sticky : assert property (@(posedge clk_io)
		$fell(tim.lock) |-> !$past(rst_n))
		else $error("lock fell without rst_n low");

endmodule

`default_nettype wire

//--- src/deser_timing_if.sv
// deserializer timing bundle
`default_nettype none
`timescale 1ns/1ps

interface deser_timing_if;

	import deser_link_pkg::*;

	// ------------------------------------------------
	// timing signals, all in the clk_io domain
	// ------------------------------------------------
	logic   serdesstrobe;	// one cycle per word, at phase 0
	phase_t phase;			// bit position within the word
	logic   lock;			// emulated pll lock
	logic   reset_recover;	// recovered reset, active high

	// clock controller side
	modport ctrl (
		output serdesstrobe,
		output phase,
		output lock,
		output reset_recover
	);

	// data path side, handed on to every lane
	modport data (
		input serdesstrobe,
		input phase,
		input lock,
		input reset_recover
	);

endinterface

`default_nettype wire

//--- src/deser_align_pkg.sv
// lock and alignment timing
`default_nettype none

package deser_align_pkg;

	// ------------------------------------------------
	// lock emulation
	// ------------------------------------------------
	localparam int LOCK_CYCLES = 16;	// rst_n release to lock high

	// counter only has to reach LOCK_CYCLES-1
	localparam int LOCK_CNT_W = (LOCK_CYCLES > 1) ? $clog2(LOCK_CYCLES) : 1;

	// recovered reset synchronizer depth, at least 2
	localparam int RESET_SYNC_STAGES = 2;

	// ------------------------------------------------
	// bitslip
	// ------------------------------------------------
	// last slip offset before it wraps back to 0
	localparam int SLIP_WRAP = deser_link_pkg::DESER_WIDTH - 1;

endpackage

`default_nettype wire

//--- src/deser_link_pkg.sv
// deserializer link geometry
`default_nettype none

package deser_link_pkg;

	// ------------------------------------------------
	// lane count and word size
	// ------------------------------------------------
	localparam int CHANNEL_NUM = 4;	// serial lanes sharing clk_io
	localparam int DESER_WIDTH = 6;	// bits per lane word, 2..8 sensible

	// phase counter needs to reach DESER_WIDTH-1
	localparam int PHASE_W = (DESER_WIDTH > 1) ? $clog2(DESER_WIDTH) : 1;

	// ------------------------------------------------
	// bit and channel order
	// ------------------------------------------------
	// first bit on the wire lands in word bit 0
	localparam bit SER_FIRST_LSB = 1'b1;
	// little: {ch3 ch2 ch1 ch0}, big: {ch0 ch1 ch2 ch3}
	localparam bit END_LITTLE = 1'b1;

	// ------------------------------------------------
	// types
	// ------------------------------------------------
	typedef logic [DESER_WIDTH-1:0] lane_word_t;	// one lane word

	// packed output, slot 0 in the low bits
	typedef lane_word_t [CHANNEL_NUM-1:0] data_bus_t;

	typedef logic [PHASE_W-1:0] phase_t;	// word phase, 0..DESER_WIDTH-1

endpackage

`default_nettype wire
